// File: bench/gfx_checker.sv
/*
 * Scoreboard for the tilemap controller
 * Mirrors APB writes, predicts each line and the interrupt,
 * and compares pixels, readback and irq against the DUT
 */
module gfx_checker (
    input logic          clk,
    input logic          rst,
    input logic          psel,
    input logic          penable,
    input logic          pwrite,
    input logic [9:0]    paddr,
    input logic [15:0]   pwdata,
    input logic [15:0]   prdata,
    input logic          vblank,
    input logic          irq,
    input logic          line_start,
    input logic [6:0]    vrender,
    input logic          pix_en,
    input logic [6:0]    hdump,
    input gfx_pkg::pxl_t pxl_out,
    input logic          pxl_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0]          regs [8];
    gfx_pkg::vram_entry_t vchr [256];
    gfx_pkg::vram_entry_t vscr [256];
    logic [3:0]           next_chr [128];
    logic [3:0]           next_scr [128];
    logic [3:0]           shown_chr [128];
    logic [3:0]           shown_scr [128];
    int                   pend [$];
    logic                 exp_irq;
    logic                 vb_q;
    int                   err_count = 0;
    int                   err_base = 0;
    int                   pix_count = 0;
    int                   tests_failed = 0;

    // Pixel index of one layer at screen position x from the ROM data rule
    function automatic logic [3:0] layer_pix(input bit scr, input int x, input logic [6:0] vr);
        int                   sx;
        logic [6:0]           y;
        logic [3:0]           col;
        gfx_pkg::vram_entry_t e;
        logic [10:0]          a;
        sx  = scr ? x + regs[gfx_pkg::reg_hscroll][2:0] : x;
        y   = scr ? 7'(vr + regs[gfx_pkg::reg_vscroll][6:0]) : vr;
        col = 4'((scr ? regs[gfx_pkg::reg_hscroll][6:3] : 4'd0) + sx / 8);
        e   = scr ? vscr[{y[6:3], col}] : vchr[{y[6:3], col}];
        a   = {e.code, y[2:0]};
        return 4'(a + sx % 8) ^ e.attr[3:0];
    endfunction

    function automatic gfx_pkg::pxl_t expect_pixel(input int x);
        gfx_pkg::ctrl_t c;
        gfx_pkg::pxl_t  p;
        c = gfx_pkg::ctrl_t'(regs[gfx_pkg::reg_ctrl][4:0]);
        p.pal_bank = c.pal_bank;
        if (c.chr_en && shown_chr[x] != 4'd0) begin
            p.layer = 1'b0;
            p.index = shown_chr[x];
        end else if (c.scr_en) begin
            p.layer = 1'b1;
            p.index = shown_scr[x];
        end else begin
            p.layer = 1'b1;
            p.index = 4'd0;
        end
        return p;
    endfunction

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        gfx_pkg::pxl_t exp_p;
        logic          ack;
        int            x;
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] = '0;
            end
            exp_irq = 1'b0;
            vb_q    = 1'b0;
            pend.delete();
        end else begin
            if (irq !== exp_irq) begin
                $display("error %0t: irq expected %b got %b", $time, exp_irq, irq);
                err_count++;
            end
            ack = psel && penable && pwrite && !paddr[9] && paddr[2:0] == 3'd3;
            if (vblank && !vb_q && regs[gfx_pkg::reg_ctrl][0]) begin
                exp_irq = 1'b1;
            end else if (ack) begin
                exp_irq = 1'b0;
            end
            vb_q = vblank;

            if (psel && penable && !pwrite) begin
                if (prdata !== (paddr[9] ? 16'h0 : regs[paddr[2:0]])) begin
                    $display("error %0t: read of %h returned %h", $time, paddr, prdata);
                    err_count++;
                end
            end

            if (line_start) begin
                shown_chr = next_chr;
                shown_scr = next_scr;
                for (int i = 0; i < 128; i++) begin
                    next_chr[i] = layer_pix(1'b0, i, vrender);
                    next_scr[i] = layer_pix(1'b1, i, vrender);
                end
            end

            if (pxl_valid) begin
                if (pend.size() == 0) begin
                    $display("pixel came out at %0t without a request", $time);
                    err_count++;
                end else begin
                    x     = pend.pop_front();
                    exp_p = expect_pixel(x);
                    pix_count++;
                    if (pxl_out !== exp_p) begin
                        $display("error %0t: pixel %0d expected %h got %h",
                                 $time, x, exp_p, pxl_out);
                        err_count++;
                    end
                end
            end
            if (pix_en) begin
                pend.push_back(int'(hdump));
            end

            // Shadow copy of every write
            if (psel && penable && pwrite) begin
                if (!paddr[9]) begin
                    regs[paddr[2:0]] = pwdata;
                end else if (paddr[8]) begin
                    vscr[paddr[7:0]] = gfx_pkg::vram_entry_t'(pwdata);
                end else begin
                    vchr[paddr[7:0]] = gfx_pkg::vram_entry_t'(pwdata);
                end
            end
        end
    end

    task automatic report_test(input int t);
        int errs;
        if (pix_count != gfx_pkg::screen_w) begin
            $display("test %0d: %0d pixels came out instead of 128", t, pix_count);
            err_count++;
        end
        errs = err_count - err_base;
        $display("test %0d: %0d pixels checked, %0d errors, %s",
                 t, pix_count, errs, errs == 0 ? "ok" : "bad");
        if (errs != 0) begin
            tests_failed++;
        end
        err_base  = err_count;
        pix_count = 0;
    endtask

endmodule

// File: bench/gfx_clkgen.sv
/*
 * Clock and reset source for the tilemap testbench
 * 10 ns clock, reset held for two cycles
 */
module gfx_clkgen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: bench/gfx_properties.sv
/*
 * Concurrent checks on the tile ROM handshake
 * Bound into the ROM arbiter
 */
module gfx_properties (
    input logic                       clk,
    input logic                       rst,
    input gfx_pkg::rom_req_t          req_chr,
    input gfx_pkg::rom_req_t          req_scr,
    input logic                       rom_cs,
    input logic                       rom_ok,
    input logic [gfx_pkg::rom_aw-1:0] rom_addr,
    input logic                       ack_chr,
    input logic                       ack_scr
);
    timeunit 1ns;
    timeprecision 100ps;

    // Request stays up with a steady address until the ROM answers
    assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom_cs dropped or rom_addr moved before rom_ok");

    // Each fetcher keeps its request and address until it is acknowledged
    assert property (@(posedge clk) disable iff (rst)
        req_chr.valid && !ack_chr |=> req_chr.valid && $stable(req_chr.addr))
        else $error("char fetcher request dropped or changed before its ack");

    assert property (@(posedge clk) disable iff (rst)
        req_scr.valid && !ack_scr |=> req_scr.valid && $stable(req_scr.addr))
        else $error("scroll fetcher request dropped or changed before its ack");

    assert property (@(posedge clk) disable iff (rst)
        ack_chr || ack_scr |-> $past(rom_cs && rom_ok))
        else $error("ack without a completed ROM transaction");

    assert property (@(posedge clk) disable iff (rst) rom_cs && rom_ok |=> !rom_cs)
        else $error("rom_cs still high after rom_ok");

endmodule

bind gfx_rom_arbiter gfx_properties u_props (
    .clk, .rst, .req_chr, .req_scr, .rom_cs, .rom_ok, .rom_addr, .ack_chr, .ack_scr
);

// File: bench/gfx_tb.sv
/*
 * Testbench for the tilemap controller
 * Each table row programs both layers, renders a line,
 * shows it and pulses vblank
 */
module gfx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [7:0] hs;
        logic [7:0] vs;
        logic [4:0] ctrl;
        logic [7:0] seed;
        logic [6:0] vr;
    } test_row_t;

    // Control bits are pal_bank 4:3, scr_en 2, chr_en 1 and irq_en 0
    test_row_t rows [6] = '{
        '{8'h00, 8'h00, 5'h0A, 8'h00, 7'd5},
        '{8'h2B, 8'h13, 5'h14, 8'h37, 7'd40},
        '{8'h05, 8'h71, 5'h1E, 8'h80, 7'd100},
        '{8'hC7, 8'h0F, 5'h07, 8'hF3, 7'd127},
        '{8'h10, 8'h40, 5'h11, 8'h11, 7'd64},
        '{8'h9E, 8'hFF, 5'h0F, 8'h5A, 7'd0}
    };

    logic          clk, rst;
    logic          psel, penable, pwrite, pready;
    logic [9:0]    paddr;
    logic [15:0]   pwdata, prdata;
    logic          vblank, irq, line_start, line_ready, pix_en, pxl_valid;
    logic [6:0]    vrender, hdump;
    gfx_pkg::pxl_t pxl_out;
    logic [10:0]   rom_addr;
    logic          rom_cs, rom_ok;
    logic [31:0]   rom_data;
    int            rom_wait;
    bit            hung = 1'b0;

    gfx_clkgen u_clkgen (.clk, .rst);
    gfx_top gfx_top_i (.*);
    gfx_checker chk (.*);

    function automatic logic [31:0] rom_word(input logic [10:0] a);
        logic [31:0] w;
        for (int k = 0; k < 8; k++) begin
            w[k*4 +: 4] = 4'(a + k);
        end
        return w;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic note_timeout(input string why);
        $display("%s", why);
        hung = 1'b1;
    endtask

    task automatic apb_access(input logic wr, input logic [9:0] a, input logic [15:0] d);
        int n;
        step();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        step();
        penable = 1'b1;
        n = 0;
        while (!pready && n < 16) begin
            step();
            n++;
        end
        if (!pready) note_timeout("APB transfer never completed, pready stuck low");
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic start_line(input logic [6:0] vr);
        step();
        line_start = 1'b1;
        vrender    = vr;
        step();
        line_start = 1'b0;
    endtask

    task automatic wait_line_ready();
        int n;
        n = 0;
        while (!line_ready && n < 5000) begin
            step();
            n++;
        end
        if (!line_ready) note_timeout("line_ready did not rise within 5000 cycles");
    endtask

    // Answers each ROM request after 1 to 4 cycles
    initial begin
        void'($urandom(84668));
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_wait = 0;
        forever begin
            step();
            if (rom_ok) begin
                rom_ok = 1'b0;
            end else if (rom_cs) begin
                if (rom_wait == 0) rom_wait = $urandom_range(4, 1);
                rom_wait--;
                if (rom_wait == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_word(rom_addr);
                end
            end
        end
    end

    initial begin
        int n;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {vblank, line_start, vrender, pix_en, hdump} = '0;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            step();
            n++;
        end
        if (rst !== 1'b0) note_timeout("reset never released");
        foreach (rows[t]) begin
            if (hung) break;
            apb_access(1'b1, 10'(gfx_pkg::reg_hscroll), {8'h0, rows[t].hs});
            apb_access(1'b1, 10'(gfx_pkg::reg_vscroll), {8'h0, rows[t].vs});
            apb_access(1'b1, 10'(gfx_pkg::reg_ctrl), {11'h0, rows[t].ctrl});
            for (int r = 4; r < 8; r++) begin
                apb_access(1'b1, 10'(r), 16'(rows[t].seed * r + t));
            end
            for (int e = 0; e < 256; e++) begin
                apb_access(1'b1, 10'h200 | 10'(e), {8'(rows[t].seed + e), 8'(e % 4)});
                apb_access(1'b1, 10'h300 | 10'(e), {8'(rows[t].seed + e), 8'(e % 4)});
            end
            for (int r = 0; r < 8; r++) begin
                apb_access(1'b0, 10'(r), 16'h0);
            end
            apb_access(1'b0, 10'h2A5, 16'h0);
            start_line(rows[t].vr);
            wait_line_ready();
            // The second line brings the rendered one onto the display half
            start_line(rows[t].vr + 7'd1);
            wait_line_ready();
            for (int x = 0; x < gfx_pkg::screen_w; x++) begin
                step();
                pix_en = 1'b1;
                hdump  = 7'(x);
            end
            step();
            pix_en = 1'b0;
            step();
            vblank = 1'b1;
            repeat (3) step();
            vblank = 1'b0;
            repeat (2) step();
            apb_access(1'b1, 10'(gfx_pkg::reg_irq_ack), 16'h0);
            repeat (4) step();
            chk.report_test(t);
        end
        $display("tests %0d, failed %0d, errors %0d",
                 $size(rows), chk.tests_failed, chk.err_count);
        if (!hung && chk.err_count == 0 && chk.tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the tilemap controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module gfx_tb -f src.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vgfx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

// File: src.f
verilog/gfx_pkg.sv
verilog/gfx_dpram.sv
verilog/gfx_regs.sv
verilog/gfx_tile_fetch.sv
verilog/gfx_rom_arbiter.sv
verilog/gfx_mixer.sv
verilog/gfx_top.sv
bench/gfx_clkgen.sv
bench/gfx_properties.sv
bench/gfx_checker.sv
bench/gfx_tb.sv

// File: verilog/gfx_dpram.sv
/*
 * Simple dual port RAM, one write and one registered read port
 * The stored word is given as a type parameter
 */
module gfx_dpram #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // One cycle of read latency
        rdata <= mem[raddr];
    end

endmodule

// File: verilog/gfx_mixer.sv
/*
 * Layer mixer
 * Reads both line buffers at the pixel position, picks the
 * char layer unless it is transparent and adds the palette bank
 */
module gfx_mixer (
    input  logic               clk,
    input  logic               rst,
    input  logic               pix_en,
    input  logic [6:0]         hdump,
    input  logic               line_half,
    input  gfx_pkg::ctrl_t     ctrl,
    input  gfx_pkg::line_pix_t chr_rdata,
    input  gfx_pkg::line_pix_t scr_rdata,
    output logic [7:0]         lb_raddr,
    output gfx_pkg::pxl_t      pxl_out,
    output logic               pxl_valid
);

    logic          en_q;
    gfx_pkg::pxl_t pick;

    assign lb_raddr = {line_half, hdump};

    always_comb begin
        pick.pal_bank = ctrl.pal_bank;
        if (ctrl.chr_en && chr_rdata.index != '0) begin
            pick.layer = 1'b0;
            pick.index = chr_rdata.index;
        end else if (ctrl.scr_en) begin
            pick.layer = 1'b1;
            pick.index = scr_rdata.index;
        end else begin
            // Both layers off or char transparent with scroll off
            pick.layer = 1'b1;
            pick.index = '0;
        end
    end

    // First stage matches the line buffer read
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            en_q      <= 1'b0;
            pxl_valid <= 1'b0;
        end else begin
            en_q      <= pix_en;
            pxl_valid <= en_q;
        end
    end

    always_ff @(posedge clk) begin
        if (en_q) begin
            pxl_out <= pick;
        end
    end

endmodule

// File: verilog/gfx_pkg.sv
/*
 * Tilemap video controller shared definitions
 * Sizes, register map and the structs passed between the
 * register block, fetchers, ROM arbiter and mixer
 */
package gfx_pkg;

    // Screen and tile geometry
    localparam int tiles_per_row = 16;
    localparam int screen_w      = 128;
    localparam int pix_w         = 4;

    // Memory sizes
    localparam int vram_depth = 256;
    localparam int lb_depth   = 256;
    localparam int rom_aw     = 11;

    // APB bus widths
    localparam int apb_aw = 10;
    localparam int apb_dw = 16;

    // Register map
    localparam int reg_count   = 8;
    localparam int reg_hscroll = 0;
    localparam int reg_vscroll = 1;
    localparam int reg_ctrl    = 2;
    localparam int reg_irq_ack = 3;

    // Control register with irq_en in bit 0
    typedef struct packed {
        logic [1:0] pal_bank;
        logic       scr_en;
        logic       chr_en;
        logic       irq_en;
    } ctrl_t;

    // Attr low nibble is xored into every pixel of the tile
    typedef struct packed {
        logic [7:0] code;
        logic [7:0] attr;
    } vram_entry_t;

    typedef struct packed {
        logic [pix_w-1:0] index;
    } line_pix_t;

    // Address is the tile code followed by the tile row
    typedef struct packed {
        logic [rom_aw-1:0] addr;
        logic              valid;
    } rom_req_t;

    typedef struct packed {
        logic [1:0]       pal_bank;
        logic             layer;
        logic [pix_w-1:0] index;
    } pxl_t;

endpackage

// File: verilog/gfx_regs.sv
/*
 * APB register block for the tilemap controller
 * Holds the configuration registers, drives the VRAM write
 * port and keeps the vertical blank interrupt
 */
module gfx_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [gfx_pkg::apb_aw-1:0]  paddr,
    input  logic [gfx_pkg::apb_dw-1:0]  pwdata,
    output logic [gfx_pkg::apb_dw-1:0]  prdata,
    output logic                        pready,
    input  logic                        vblank,
    output logic                        irq,
    output logic [7:0]                  hscroll,
    output logic [7:0]                  vscroll,
    output gfx_pkg::ctrl_t              ctrl,
    output logic                        vram_we_chr,
    output logic                        vram_we_scr,
    output logic [7:0]                  vram_waddr,
    output gfx_pkg::vram_entry_t        vram_wdata
);

    logic [gfx_pkg::apb_dw-1:0] regs [gfx_pkg::reg_count];
    logic wr;
    logic reg_sel;
    logic ack_wr;
    logic vblank_q;

    // Every transfer finishes in its access phase
    assign pready  = 1'b1;
    assign wr      = psel & penable & pwrite;
    assign reg_sel = ~paddr[9];
    assign ack_wr  = wr & reg_sel & (paddr[2:0] == 3'(gfx_pkg::reg_irq_ack));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < gfx_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr && reg_sel) begin
            regs[paddr[2:0]] <= pwdata;
        end
    end

    // VRAM is write-only from the CPU side
    assign prdata = reg_sel ? regs[paddr[2:0]] : '0;

    assign hscroll = regs[gfx_pkg::reg_hscroll][7:0];
    assign vscroll = regs[gfx_pkg::reg_vscroll][7:0];
    assign ctrl    = gfx_pkg::ctrl_t'(regs[gfx_pkg::reg_ctrl][$bits(gfx_pkg::ctrl_t)-1:0]);

    // Bit 8 picks the layer and is set for scroll
    assign vram_we_chr = wr & paddr[9] & ~paddr[8];
    assign vram_we_scr = wr & paddr[9] & paddr[8];
    assign vram_waddr  = paddr[7:0];
    assign vram_wdata  = gfx_pkg::vram_entry_t'(pwdata);

    // A new vblank edge wins over a simultaneous acknowledge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vblank_q <= 1'b0;
            irq      <= 1'b0;
        end else begin
            vblank_q <= vblank;
            if (vblank && !vblank_q && ctrl.irq_en) begin
                irq <= 1'b1;
            end else if (ack_wr) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/gfx_rom_arbiter.sv
/*
 * Tile ROM arbiter
 * Shares the external ROM port between the char and scroll
 * fetchers, char first, one transaction at a time
 */
module gfx_rom_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  gfx_pkg::rom_req_t           req_chr,
    input  gfx_pkg::rom_req_t           req_scr,
    output logic                        ack_chr,
    output logic                        ack_scr,
    output logic [31:0]                 data_out,
    output logic [gfx_pkg::rom_aw-1:0]  rom_addr,
    output logic                        rom_cs,
    input  logic [31:0]                 rom_data,
    input  logic                        rom_ok
);

    typedef enum logic [1:0] {a_idle, a_chr, a_scr} arb_t;

    arb_t state;
    logic go_chr;
    logic go_scr;

    // A request is still up during its ack cycle, so it is not served again
    assign go_chr = req_chr.valid & ~ack_chr;
    assign go_scr = req_scr.valid & ~ack_scr;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= a_idle;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            ack_chr  <= 1'b0;
            ack_scr  <= 1'b0;
        end else begin
            ack_chr <= 1'b0;
            ack_scr <= 1'b0;
            case (state)
                a_idle: begin
                    if (go_chr) begin
                        rom_cs   <= 1'b1;
                        rom_addr <= req_chr.addr;
                        state    <= a_chr;
                    end else if (go_scr) begin
                        rom_cs   <= 1'b1;
                        rom_addr <= req_scr.addr;
                        state    <= a_scr;
                    end
                end
                default: begin
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        ack_chr <= (state == a_chr);
                        ack_scr <= (state == a_scr);
                        state   <= a_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) begin
            data_out <= rom_data;
        end
    end

endmodule

// File: verilog/gfx_tile_fetch.sv
/*
 * Line renderer for one tilemap layer
 * Walks the tiles of the current row, fetches one ROM word per
 * tile and writes eight pixels of it into the line buffer
 */
module gfx_tile_fetch #(
    parameter bit scrolled = 1'b0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 line_start,
    input  logic [6:0]           vrender,
    input  logic [7:0]           hscroll,
    input  logic [7:0]           vscroll,
    output logic [7:0]           vram_raddr,
    input  gfx_pkg::vram_entry_t vram_rdata,
    output gfx_pkg::rom_req_t    rom_req,
    input  logic                 rom_ack,
    input  logic [31:0]          rom_data,
    output logic                 lb_we,
    output logic [7:0]           lb_addr,
    output gfx_pkg::line_pix_t   lb_wdata,
    output logic                 done
);

    // One extra tile covers the fine scroll offset
    localparam int last_tile = scrolled ? gfx_pkg::tiles_per_row : gfx_pkg::tiles_per_row - 1;

    typedef enum logic [2:0] {s_idle, s_ram, s_req, s_wr, s_done} state_t;

    state_t      state;
    logic [6:0]  ypos;
    logic [3:0]  col0;
    logic [2:0]  fine;
    logic [4:0]  tile;
    logic [2:0]  k;
    logic        wr_half;
    logic [31:0] pix;
    logic [3:0]  pal_xor;
    logic [8:0]  xs;

    assign vram_raddr    = {ypos[6:3], col0 + tile[3:0]};
    assign rom_req.addr  = {vram_rdata.code, ypos[2:0]};
    assign rom_req.valid = (state == s_req);

    // Screen position of the pixel being written goes negative when shifted out
    assign xs = {1'b0, tile, k} - {6'd0, fine};

    assign lb_we          = (state == s_wr) && !xs[8] && (xs[7:0] < gfx_pkg::screen_w);
    assign lb_addr        = {wr_half, xs[6:0]};
    assign lb_wdata.index = pix[gfx_pkg::pix_w-1:0] ^ pal_xor;
    assign done           = (state == s_done);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= s_idle;
            wr_half <= 1'b0;
            tile    <= '0;
            k       <= '0;
            ypos    <= '0;
            col0    <= '0;
            fine    <= '0;
        end else if (line_start) begin
            state   <= s_ram;
            wr_half <= ~wr_half;
            tile    <= '0;
            k       <= '0;
            ypos    <= vrender + (scrolled ? vscroll[6:0] : 7'd0);
            col0    <= scrolled ? hscroll[6:3] : 4'd0;
            fine    <= scrolled ? hscroll[2:0] : 3'd0;
        end else begin
            case (state)
                s_ram: state <= s_req;
                s_req: begin
                    if (rom_ack) begin
                        state <= s_wr;
                    end
                end
                s_wr: begin
                    k <= k + 3'd1;
                    if (k == 3'd7) begin
                        if (tile == last_tile) begin
                            state <= s_done;
                        end else begin
                            tile  <= tile + 5'd1;
                            state <= s_ram;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Pixel 0 sits in the low nibble of the ROM word
    always_ff @(posedge clk) begin
        if (state == s_req && rom_ack) begin
            pix     <= rom_data;
            pal_xor <= vram_rdata.attr[3:0];
        end else if (state == s_wr) begin
            pix <= pix >> gfx_pkg::pix_w;
        end
    end

endmodule

// File: verilog/gfx_top.sv
/*
 * Tilemap video controller top level
 * Two layers rendered per line from VRAM and a shared tile ROM,
 * shown from double buffered line memories
 */
module gfx_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [gfx_pkg::apb_aw-1:0]  paddr,
    input  logic [gfx_pkg::apb_dw-1:0]  pwdata,
    output logic [gfx_pkg::apb_dw-1:0]  prdata,
    output logic                        pready,
    input  logic                        vblank,
    output logic                        irq,
    input  logic                        line_start,
    input  logic [6:0]                  vrender,
    output logic                        line_ready,
    input  logic                        pix_en,
    input  logic [6:0]                  hdump,
    output gfx_pkg::pxl_t               pxl_out,
    output logic                        pxl_valid,
    output logic [gfx_pkg::rom_aw-1:0]  rom_addr,
    output logic                        rom_cs,
    input  logic [31:0]                 rom_data,
    input  logic                        rom_ok
);

    logic [7:0]           hscroll;
    logic [7:0]           vscroll;
    gfx_pkg::ctrl_t       ctrl;
    logic                 vram_we_chr;
    logic                 vram_we_scr;
    logic [7:0]           vram_waddr;
    gfx_pkg::vram_entry_t vram_wdata;
    logic [7:0]           chr_vaddr;
    logic [7:0]           scr_vaddr;
    gfx_pkg::vram_entry_t chr_ventry;
    gfx_pkg::vram_entry_t scr_ventry;
    gfx_pkg::rom_req_t    chr_req;
    gfx_pkg::rom_req_t    scr_req;
    logic                 chr_ack;
    logic                 scr_ack;
    logic [31:0]          rom_word;
    logic                 chr_lb_we;
    logic                 scr_lb_we;
    logic [7:0]           chr_lb_addr;
    logic [7:0]           scr_lb_addr;
    gfx_pkg::line_pix_t   chr_lb_wdata;
    gfx_pkg::line_pix_t   scr_lb_wdata;
    gfx_pkg::line_pix_t   chr_pix;
    gfx_pkg::line_pix_t   scr_pix;
    logic                 chr_done;
    logic                 scr_done;
    logic [7:0]           lb_raddr;
    logic                 line_parity;

    // Follows the fetchers' write half while display reads the other one
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            line_parity <= 1'b0;
        end else if (line_start) begin
            line_parity <= ~line_parity;
        end
    end

    assign line_ready = chr_done & scr_done;

    gfx_regs u_regs (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .vblank, .irq, .hscroll, .vscroll, .ctrl,
        .vram_we_chr, .vram_we_scr, .vram_waddr, .vram_wdata
    );

    gfx_dpram #(.payload_t(gfx_pkg::vram_entry_t), .depth(gfx_pkg::vram_depth)) u_vram_chr (
        .clk, .we(vram_we_chr), .waddr(vram_waddr), .wdata(vram_wdata),
        .raddr(chr_vaddr), .rdata(chr_ventry)
    );

    gfx_dpram #(.payload_t(gfx_pkg::vram_entry_t), .depth(gfx_pkg::vram_depth)) u_vram_scr (
        .clk, .we(vram_we_scr), .waddr(vram_waddr), .wdata(vram_wdata),
        .raddr(scr_vaddr), .rdata(scr_ventry)
    );

    gfx_tile_fetch #(.scrolled(1'b0)) u_fetch_chr (
        .clk, .rst, .line_start, .vrender, .hscroll, .vscroll,
        .vram_raddr(chr_vaddr), .vram_rdata(chr_ventry),
        .rom_req(chr_req), .rom_ack(chr_ack), .rom_data(rom_word),
        .lb_we(chr_lb_we), .lb_addr(chr_lb_addr), .lb_wdata(chr_lb_wdata), .done(chr_done)
    );

    gfx_tile_fetch #(.scrolled(1'b1)) u_fetch_scr (
        .clk, .rst, .line_start, .vrender, .hscroll, .vscroll,
        .vram_raddr(scr_vaddr), .vram_rdata(scr_ventry),
        .rom_req(scr_req), .rom_ack(scr_ack), .rom_data(rom_word),
        .lb_we(scr_lb_we), .lb_addr(scr_lb_addr), .lb_wdata(scr_lb_wdata), .done(scr_done)
    );

    gfx_rom_arbiter u_arbiter (
        .clk, .rst, .req_chr(chr_req), .req_scr(scr_req),
        .ack_chr(chr_ack), .ack_scr(scr_ack), .data_out(rom_word),
        .rom_addr, .rom_cs, .rom_data, .rom_ok
    );

    gfx_dpram #(.payload_t(gfx_pkg::line_pix_t), .depth(gfx_pkg::lb_depth)) u_line_chr (
        .clk, .we(chr_lb_we), .waddr(chr_lb_addr), .wdata(chr_lb_wdata),
        .raddr(lb_raddr), .rdata(chr_pix)
    );

    gfx_dpram #(.payload_t(gfx_pkg::line_pix_t), .depth(gfx_pkg::lb_depth)) u_line_scr (
        .clk, .we(scr_lb_we), .waddr(scr_lb_addr), .wdata(scr_lb_wdata),
        .raddr(lb_raddr), .rdata(scr_pix)
    );

    gfx_mixer u_mixer (
        .clk, .rst, .pix_en, .hdump, .line_half(~line_parity), .ctrl,
        .chr_rdata(chr_pix), .scr_rdata(scr_pix), .lb_raddr, .pxl_out, .pxl_valid
    );

endmodule
